// ==== Makefile ====
SIM        ?= verilator
TOP        ?= tb_ahb2apb
FILELIST   ?= build.f
OBJ_DIR    ?= obj_dir
SIM_FLAGS  ?= --binary --assert --timing -j 0
LINT_FLAGS ?= --lint-only --timing
PASS_MSG   := Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== build.f ====
src/ahb_pkg.sv
src/apb_pkg.sv
src/ahb_data_phase.sv
src/apb_slave_decode.sv
src/apb_sequencer.sv
src/apb_response_mux.sv
src/ahb2apb_bridge.sv
tests/tb_ahb2apb.sv

// ==== src/ahb2apb_bridge.sv ====
// AHB to APB bridge top level
`timescale 1ns/1ps

module ahb2apb_bridge #(
  parameter int num_slaves = 4,
  parameter logic [num_slaves-1:0][ahb_pkg::addr_w-1:0] slave_base = {
    32'h0000_3000, 32'h0000_2000, 32'h0000_1000, 32'h0000_0000
  },
  parameter logic [num_slaves-1:0][ahb_pkg::addr_w-1:0] slave_limit = {
    32'h0000_3FFF, 32'h0000_2FFF, 32'h0000_1FFF, 32'h0000_0FFF
  }
) (
  input  logic                               hclk23,
  input  logic                               hreset_n23,
  // AHB slave port
  input  logic                               hsel,
  input  ahb_pkg::htrans_t                   htrans,
  input  logic [ahb_pkg::addr_w-1:0]         haddr,
  input  logic                               hwrite,
  input  logic [ahb_pkg::data_w-1:0]         hwdata,
  output logic                               hready,
  output logic [ahb_pkg::data_w-1:0]         hrdata,
  // APB master port
  input  apb_pkg::apb_rsp_t [num_slaves-1:0] slave_rsp,
  output logic [num_slaves-1:0]              psel,
  output logic                               penable,
  output logic [ahb_pkg::addr_w-1:0]         paddr,
  output logic                               pwrite,
  output logic [ahb_pkg::data_w-1:0]         pwdata
);

  import ahb_pkg::*;

  logic                  accept;
  ahb_req_t              req;
  logic                  req_pending;
  logic [num_slaves-1:0] slave_sel;
  logic                  xfer_done;
  logic                  pready_sel;
  logic [data_w-1:0]     prdata_sel;

  // Write data straight from the AHB data phase
  assign pwdata = hwdata;

  ahb_data_phase u_ahb_data_phase (
    .hclk23      (hclk23),
    .hreset_n23  (hreset_n23),
    .hsel        (hsel),
    .htrans      (htrans),
    .haddr       (haddr),
    .hwrite      (hwrite),
    .xfer_done   (xfer_done),
    .prdata_sel  (prdata_sel),
    .hready      (hready),
    .hrdata      (hrdata),
    .accept      (accept),
    .req         (req),
    .req_pending (req_pending)
  );

  apb_slave_decode #(
    .num_slaves  (num_slaves),
    .slave_base  (slave_base),
    .slave_limit (slave_limit)
  ) u_apb_slave_decode (
    .hclk23      (hclk23),
    .hreset_n23  (hreset_n23),
    .accept      (accept),
    .haddr       (haddr),
    .slave_sel   (slave_sel)
  );

  apb_sequencer #(
    .num_slaves  (num_slaves)
  ) u_apb_sequencer (
    .hclk23      (hclk23),
    .hreset_n23  (hreset_n23),
    .req         (req),
    .req_pending (req_pending),
    .slave_sel   (slave_sel),
    .pready_sel  (pready_sel),
    .psel        (psel),
    .penable     (penable),
    .paddr       (paddr),
    .pwrite      (pwrite),
    .xfer_done   (xfer_done)
  );

  apb_response_mux #(
    .num_slaves  (num_slaves)
  ) u_apb_response_mux (
    .psel        (psel),
    .slave_rsp   (slave_rsp),
    .pready_sel  (pready_sel),
    .prdata_sel  (prdata_sel)
  );

endmodule

// ==== src/ahb_data_phase.sv ====
// AHB transfer acceptance and data phase
`timescale 1ns/1ps

module ahb_data_phase (
  input  logic                       hclk23,
  input  logic                       hreset_n23,
  input  logic                       hsel,
  input  ahb_pkg::htrans_t           htrans,
  input  logic [ahb_pkg::addr_w-1:0] haddr,
  input  logic                       hwrite,
  input  logic                       xfer_done,
  input  logic [ahb_pkg::data_w-1:0] prdata_sel,
  output logic                       hready,
  output logic [ahb_pkg::data_w-1:0] hrdata,
  output logic                       accept,
  output ahb_pkg::ahb_req_t          req,
  output logic                       req_pending
);

  import ahb_pkg::*;

  logic valid_trans;

  // Only NONSEQ and SEQ carry a transfer; IDLE and BUSY are ignored
  assign valid_trans = hsel && ((htrans == trans_nonseq) || (htrans == trans_seq));

  // hready is high only while no transfer is open
  assign accept = hready && valid_trans;

  // --------------------------------------------------
  // Address phase capture and data phase tracking
  // --------------------------------------------------
  always_ff @(posedge hclk23 or negedge hreset_n23) begin
    if (!hreset_n23) begin
      hready      <= 1'b1;
      req_pending <= 1'b0;
      req         <= '0;
      hrdata      <= '0;
    end else if (accept) begin
      // Close the bus until the APB side finishes
      hready      <= 1'b0;
      req_pending <= 1'b1;
      req.addr    <= haddr;
      req.write   <= hwrite;
    end else if (xfer_done) begin
      hready      <= 1'b1;
      req_pending <= 1'b0;
      // Loaded on writes too, the master ignores it then
      hrdata      <= prdata_sel;
    end
  end

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------
  // The bus is never open while a request is still in flight
  a_hready_vs_pending: assert property (
    @(posedge hclk23) disable iff (!hreset_n23)
    !(hready && req_pending)
  ) else $error("hready high with a request pending");

  // Sequencer completes only requests handed over from here
  a_done_needs_pending: assert property (
    @(posedge hclk23) disable iff (!hreset_n23)
    xfer_done |-> req_pending
  ) else $error("xfer_done without a pending request");

endmodule

// ==== src/ahb_pkg.sv ====
// AHB bus definitions
package ahb_pkg;

  // --------------------------------------------------
  // Bus widths
  // --------------------------------------------------
  localparam int addr_w = 32;
  localparam int data_w = 32;

  // --------------------------------------------------
  // Transfer type codes on htrans
  // --------------------------------------------------
  typedef enum logic [1:0] {
    trans_idle   = 2'b00,
    trans_busy   = 2'b01,
    trans_nonseq = 2'b10,
    trans_seq    = 2'b11
  } htrans_t;

  // --------------------------------------------------
  // Request captured at the end of the address phase
  // --------------------------------------------------
  // Address and direction only; write data stays on hwdata,
  // which the master holds while hready is low
  typedef struct packed {
    logic [addr_w-1:0] addr;
    logic              write;
  } ahb_req_t;

endpackage

// ==== src/apb_pkg.sv ====
// APB side definitions
package apb_pkg;

  // --------------------------------------------------
  // Slave map limits
  // --------------------------------------------------
  // Largest slave count the address map may describe
  localparam int max_slaves = 16;

  // --------------------------------------------------
  // Transfer FSM
  // --------------------------------------------------
  // One-hot encoding, one flop per phase
  typedef enum logic [2:0] {
    apb_idle   = 3'b001,
    apb_setup  = 3'b010,
    apb_access = 3'b100
  } apb_state_t;

  // --------------------------------------------------
  // Per-slave response
  // --------------------------------------------------
  // Driven by each APB slave back into the bridge;
  // prdata only matters while that slave is selected
  typedef struct packed {
    logic                        pready;
    logic [ahb_pkg::data_w-1:0]  prdata;
  } apb_rsp_t;

endpackage

// ==== src/apb_response_mux.sv ====
// APB slave response select
`timescale 1ns/1ps

module apb_response_mux #(
  parameter int num_slaves = 4
) (
  input  logic [num_slaves-1:0]                  psel,
  input  apb_pkg::apb_rsp_t [num_slaves-1:0]     slave_rsp,
  output logic                                   pready_sel,
  output logic [ahb_pkg::data_w-1:0]             prdata_sel
);

  // AND-OR select keyed on psel
  // An idle slave contributes zeros whatever it drives
  always_comb begin
    pready_sel = 1'b0;
    prdata_sel = '0;
    for (int i = 0; i < num_slaves; i++) begin
      if (psel[i]) begin
        pready_sel = pready_sel | slave_rsp[i].pready;
        prdata_sel = prdata_sel | slave_rsp[i].prdata;
      end
    end
  end

  // At most one slave selected at a time
  always_comb begin
    a_psel_onehot0: assert ($onehot0(psel))
      else $error("more than one psel bit set: %b", psel);
  end

endmodule

// ==== src/apb_sequencer.sv ====
// APB transfer sequencer
`timescale 1ns/1ps

module apb_sequencer #(
  parameter int num_slaves = 4
) (
  input  logic                       hclk23,
  input  logic                       hreset_n23,
  input  ahb_pkg::ahb_req_t          req,
  input  logic                       req_pending,
  input  logic [num_slaves-1:0]      slave_sel,
  input  logic                       pready_sel,
  output logic [num_slaves-1:0]      psel,
  output logic                       penable,
  output logic [ahb_pkg::addr_w-1:0] paddr,
  output logic                       pwrite,
  output logic                       xfer_done
);

  import apb_pkg::*;

  apb_state_t state;

  // Completion seen by the AHB side on the same edge the FSM leaves ACCESS
  assign xfer_done = (state == apb_access) && pready_sel;

  // --------------------------------------------------
  // IDLE -> SETUP -> ACCESS -> IDLE
  // --------------------------------------------------
  always_ff @(posedge hclk23 or negedge hreset_n23) begin
    if (!hreset_n23) begin
      state   <= apb_idle;
      psel    <= '0;
      penable <= 1'b0;
      paddr   <= '0;
      pwrite  <= 1'b0;
    end else begin
      case (state)
        apb_idle: begin
          if (req_pending) begin
            state  <= apb_setup;
            psel   <= slave_sel;
            paddr  <= req.addr;
            pwrite <= req.write;
          end
        end
        apb_setup: begin
          state   <= apb_access;
          penable <= 1'b1;
        end
        apb_access: begin
          // Wait states hold every output as is
          if (pready_sel) begin
            state   <= apb_idle;
            psel    <= '0;
            penable <= 1'b0;
          end
        end
        default: begin
          state   <= apb_idle;
          psel    <= '0;
          penable <= 1'b0;
        end
      endcase
    end
  end

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------
  a_penable_with_psel: assert property (
    @(posedge hclk23) disable iff (!hreset_n23)
    penable |-> (psel != '0)
  ) else $error("penable without psel");

  a_addr_stable: assert property (
    @(posedge hclk23) disable iff (!hreset_n23)
    (|psel) ##1 (|psel) |-> ($stable(paddr) && $stable(pwrite))
  ) else $error("paddr or pwrite changed during a transfer");

endmodule

// ==== src/apb_slave_decode.sv ====
// APB slave address decoder
`timescale 1ns/1ps

module apb_slave_decode #(
  parameter int num_slaves = 4,
  parameter logic [num_slaves-1:0][ahb_pkg::addr_w-1:0] slave_base = {
    32'h0000_3000, 32'h0000_2000, 32'h0000_1000, 32'h0000_0000
  },
  parameter logic [num_slaves-1:0][ahb_pkg::addr_w-1:0] slave_limit = {
    32'h0000_3FFF, 32'h0000_2FFF, 32'h0000_1FFF, 32'h0000_0FFF
  }
) (
  input  logic                       hclk23,
  input  logic                       hreset_n23,
  input  logic                       accept,
  input  logic [ahb_pkg::addr_w-1:0] haddr,
  output logic [num_slaves-1:0]      slave_sel
);

  import apb_pkg::*;

  logic [num_slaves-1:0] hit;

  // Slave count must fit the address map
  if ((num_slaves < 1) || (num_slaves > max_slaves)) begin : g_bad_count
    $error("num_slaves out of range 1 to %0d", max_slaves);
  end

  // Inclusive range compare on the live address phase
  always_comb begin
    for (int i = 0; i < num_slaves; i++) begin
      hit[i] = (haddr >= slave_base[i]) && (haddr <= slave_limit[i]);
    end
  end

  // Held until the next accept
  always_ff @(posedge hclk23 or negedge hreset_n23) begin
    if (!hreset_n23) begin
      slave_sel <= '0;
    end else if (accept) begin
      slave_sel <= hit;
    end
  end

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------
  // Overlapping ranges would select two slaves at once
  a_sel_onehot0: assert property (
    @(posedge hclk23) disable iff (!hreset_n23)
    $onehot0(slave_sel)
  ) else $error("slave select is not one-hot: %b", slave_sel);

  // Flags accepted addresses outside every range
  a_accept_mapped: assert property (
    @(posedge hclk23) disable iff (!hreset_n23)
    accept |-> $onehot(hit)
  ) else $error("accepted address %h hits %b", haddr, hit);

endmodule

// ==== tests/tb_ahb2apb.sv ====
// AHB to APB bridge testbench
`timescale 1ns/1ps

module tb_ahb2apb;

  import ahb_pkg::*;
  import apb_pkg::*;

  // Roughly 40 transfers of up to 9 cycles plus the quiet tests
  localparam int timeout_cycles  = 2000;
  localparam int pairs_per_slave = 5;

  logic              hclk23;
  logic              hreset_n23;
  logic              hsel;
  htrans_t           htrans;
  logic [addr_w-1:0] haddr;
  logic              hwrite;
  logic [data_w-1:0] hwdata;
  logic              hready;
  logic [data_w-1:0] hrdata;
  apb_rsp_t [3:0]    slave_rsp;
  logic [3:0]        psel;
  logic              penable;
  logic [addr_w-1:0] paddr;
  logic              pwrite;
  logic [data_w-1:0] pwdata;

  // Expected bus values from the master tasks
  logic [addr_w-1:0] exp_addr;
  logic              exp_write;
  logic [data_w-1:0] exp_wdata;
  logic [data_w-1:0] exp_rdata;
  logic [3:0]        exp_sel;
  logic              check_read;
  logic              quiet_check;
  logic              post_reset;

  // Slave models and bus monitor
  logic [data_w-1:0] slave_mem [4][64];
  int unsigned       wait_left [4];
  int unsigned       last_wait;
  int unsigned       low_cycles;
  int                cycle_count;

  string test_name;
  int    err_count;
  int    err_at_start;
  int    tests_run;
  int    tests_failed;

  ahb2apb_bridge uut (
    .hclk23     (hclk23),
    .hreset_n23 (hreset_n23),
    .hsel       (hsel),
    .htrans     (htrans),
    .haddr      (haddr),
    .hwrite     (hwrite),
    .hwdata     (hwdata),
    .hready     (hready),
    .hrdata     (hrdata),
    .slave_rsp  (slave_rsp),
    .psel       (psel),
    .penable    (penable),
    .paddr      (paddr),
    .pwrite     (pwrite),
    .pwdata     (pwdata)
  );

  always #4 hclk23 = ~hclk23;

  // --------------------------------------------------
  // APB slave models
  // --------------------------------------------------
  always @(posedge hclk23) begin
    int unsigned w;
    if (!hreset_n23) begin
      for (int i = 0; i < 4; i++) begin
        for (int k = 0; k < 64; k++) begin
          slave_mem[i][k] <= 32'hC0DE_0000 | (32'(i) << 12) | (32'(k) << 2);
        end
      end
    end else begin
      for (int i = 0; i < 4; i++) begin
        if (psel[i] && !penable) begin
          // SETUP picks the wait count and fetches read data
          w = $urandom_range(3, 0);
          wait_left[i]        <= w;
          last_wait           <= w;
          slave_rsp[i].pready <= (w == 0);
          slave_rsp[i].prdata <= slave_mem[i][paddr[7:2]];
        end else if (psel[i] && penable && !slave_rsp[i].pready) begin
          wait_left[i]        <= wait_left[i] - 1;
          slave_rsp[i].pready <= (wait_left[i] == 1);
        end else if (psel[i] && penable) begin
          // Completing ACCESS cycle
          if (pwrite) begin
            slave_mem[i][paddr[7:2]] <= pwdata;
          end
          slave_rsp[i].pready <= 1'b0;
        end
      end
    end
  end

  always @(posedge hclk23) begin
    if (hready) begin
      low_cycles <= 0;
    end else begin
      low_cycles <= low_cycles + 1;
    end
  end

  always @(posedge hclk23) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  task automatic report_mismatch(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("Error: %s %s expected 0x%0h actual 0x%0h", test_name, what, expected, actual);
    err_count++;
  endtask

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------
  a_reset_state: assert property (@(posedge hclk23)
    post_reset |-> hready && (psel == '0) && !penable)
    else report_mismatch("hready,psel,penable", 32'h20,
                         32'($sampled({hready, psel, penable})));

  a_psel_decode: assert property (@(posedge hclk23) disable iff (!hreset_n23)
    (|psel) |-> psel == exp_sel)
    else report_mismatch("psel", 32'(exp_sel), 32'($sampled(psel)));

  a_penable_timing: assert property (@(posedge hclk23) disable iff (!hreset_n23)
    $rose(|psel) |=> $rose(penable))
    else report_mismatch("penable one cycle after psel", 1, 32'($sampled(penable)));

  a_paddr: assert property (@(posedge hclk23) disable iff (!hreset_n23)
    (|psel) |-> paddr == exp_addr)
    else report_mismatch("paddr", exp_addr, $sampled(paddr));

  a_pwrite: assert property (@(posedge hclk23) disable iff (!hreset_n23)
    (|psel) |-> pwrite == exp_write)
    else report_mismatch("pwrite", 32'(exp_write), 32'($sampled(pwrite)));

  a_pwdata: assert property (@(posedge hclk23) disable iff (!hreset_n23)
    (|psel) |-> pwdata == exp_wdata)
    else report_mismatch("pwdata", exp_wdata, $sampled(pwdata));

  a_read_data: assert property (@(posedge hclk23) disable iff (!hreset_n23)
    check_read && $rose(hready) |-> hrdata == exp_rdata)
    else report_mismatch("hrdata", exp_rdata, $sampled(hrdata));

  // Three cycles of IDLE to ACCESS plus the slave's wait states
  a_hready_low: assert property (@(posedge hclk23) disable iff (!hreset_n23)
    $rose(hready) |-> low_cycles == 3 + last_wait)
    else report_mismatch("hready low cycles", 3 + $sampled(last_wait), $sampled(low_cycles));

  a_quiet_psel: assert property (@(posedge hclk23) disable iff (!hreset_n23)
    quiet_check |-> psel == '0)
    else report_mismatch("psel", 0, 32'($sampled(psel)));

  a_quiet_hready: assert property (@(posedge hclk23) disable iff (!hreset_n23)
    quiet_check |-> hready)
    else report_mismatch("hready", 1, 32'($sampled(hready)));

  // --------------------------------------------------
  // Master tasks
  // --------------------------------------------------
  task automatic start_test(input string name);
    test_name    = name;
    err_at_start = err_count;
  endtask

  task automatic finish_test();
    @(negedge hclk23);
    tests_run++;
    if (err_count == err_at_start) begin
      $display("Test %s: PASS", test_name);
    end else begin
      tests_failed++;
      $display("Test %s: FAIL with %0d errors", test_name, err_count - err_at_start);
    end
  endtask

  task automatic ahb_transfer(input logic [addr_w-1:0] addr, input logic write,
                              input logic [data_w-1:0] wdata, input logic read_check,
                              input logic [data_w-1:0] rdata);
    @(posedge hclk23);
    hsel      <= 1'b1;
    htrans    <= trans_nonseq;
    haddr     <= addr;
    hwrite    <= write;
    exp_addr  <= addr;
    exp_write <= write;
    // Slave ranges are 4 KB each from address zero
    exp_sel   <= 4'b0001 << addr[13:12];
    // Accept edge opens the data phase
    @(posedge hclk23);
    hsel       <= 1'b0;
    htrans     <= trans_idle;
    hwdata     <= wdata;
    exp_wdata  <= wdata;
    check_read <= read_check;
    exp_rdata  <= rdata;
    do begin
      @(posedge hclk23);
    end while (!hready);
  endtask

  task automatic run_write_read(input int slave);
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] data;
    start_test($sformatf("write_read_slave%0d", slave));
    for (int n = 0; n < pairs_per_slave; n++) begin
      addr = (32'h1000 * slave) | ($urandom & 32'h0000_0FFC);
      data = $urandom;
      ahb_transfer(addr, 1'b1, data, 1'b0, '0);
      ahb_transfer(addr, 1'b0, $urandom, 1'b1, data);
    end
    finish_test();
  endtask

  // Cycles the bridge must ignore
  task automatic drive_ignored(input string name, input logic sel, input htrans_t trans);
    start_test(name);
    @(posedge hclk23);
    quiet_check <= 1'b1;
    repeat (4) begin
      hsel   <= sel;
      htrans <= trans;
      haddr  <= $urandom & 32'h0000_3FFC;
      hwrite <= 1'($urandom);
      @(posedge hclk23);
    end
    hsel   <= 1'b0;
    htrans <= trans_idle;
    repeat (3) @(posedge hclk23);
    quiet_check <= 1'b0;
    finish_test();
  endtask

  initial begin
    void'($urandom(53));
    hclk23       = 1'b0;
    err_count    = 0;
    tests_run    = 0;
    tests_failed = 0;
    hreset_n23  <= 1'b0;
    hsel        <= 1'b0;
    htrans      <= trans_idle;
    haddr       <= '0;
    hwrite      <= 1'b0;
    hwdata      <= '0;
    slave_rsp   <= '0;
    wait_left   <= '{default: 0};
    last_wait   <= 0;
    low_cycles  <= 0;
    cycle_count <= 0;
    exp_addr    <= '0;
    exp_write   <= 1'b0;
    exp_wdata   <= '0;
    exp_rdata   <= '0;
    exp_sel     <= '0;
    check_read  <= 1'b0;
    quiet_check <= 1'b0;
    post_reset  <= 1'b0;
    start_test("reset_state");
    repeat (5) @(posedge hclk23);
    hreset_n23 <= 1'b1;
    post_reset <= 1'b1;
    @(posedge hclk23);
    post_reset <= 1'b0;
    finish_test();
    for (int s = 0; s < 4; s++) begin
      run_write_read(s);
    end
    drive_ignored("htrans_idle", 1'b1, trans_idle);
    drive_ignored("htrans_busy", 1'b1, trans_busy);
    drive_ignored("hsel_low", 1'b0, trans_nonseq);
    $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
             tests_run, tests_run - tests_failed, tests_failed, err_count);
    if ((tests_failed == 0) && (err_count == 0)) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
